// File: design/cachePkg.sv
// cache geometry, address field widths, tag entry and load request/result/miss structs
package cachePkg;

    localparam int ADDR_W = 32;
    // 16-byte lines, 16 sets
    localparam int LINE_E = 4;
    localparam int INDEX_E = 4;
    localparam int TAG_W = ADDR_W - LINE_E - INDEX_E;
    localparam int LINE_W = ADDR_W - LINE_E;

    typedef struct packed {
        logic valid;
        logic [TAG_W-1:0] tag;
    } TagEntry;

    typedef struct packed {
        logic valid;
        logic [5:0] tagDst;
        logic [ADDR_W-1:0] addr;
        // bytes supplied by the store queue
        logic [3:0] fwdMask;
        logic [31:0] fwdData;
    } LoadReq;

    typedef struct packed {
        logic valid;
        logic [5:0] tagDst;
        logic [31:0] data;
        logic nack;
        // refill for the line issued or under way, do not reissue
        logic waitRefill;
    } LoadRes;

    typedef struct packed {
        logic valid;
        logic fresh;
        logic [LINE_W-1:0] line;
    } LaneMiss;

endpackage

// File: design/memcPkg.sv
// memory-controller command codes, refill request and transfer-slot status
package memcPkg;

    localparam int NUM_TRANS = 2;
    // way part of cacheLine, room for up to four ways
    localparam int WAY_W = 2;
    localparam int CLINE_W = WAY_W + cachePkg::INDEX_E;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        REFILL = 2'd1
    } MemcCmd;

    typedef struct packed {
        MemcCmd cmd;
        logic [CLINE_W-1:0] cacheLine;
        // line aligned
        logic [cachePkg::ADDR_W-1:0] readAddr;
    } MemcReq;

    typedef struct packed {
        logic valid;
        logic [cachePkg::LINE_W-1:0] line;
    } TransferSlot;

endpackage

// File: design/tagTable.sv
// tag storage with registered per-lane reads, one write port and write forwarding
module tagTable #(
    parameter int NUM_PORTS = 2,
    parameter int ASSOC = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic re [NUM_PORTS],
    input  logic [cachePkg::INDEX_E-1:0] rIndex [NUM_PORTS],
    output cachePkg::TagEntry rdata [NUM_PORTS][ASSOC],
    input  logic we,
    input  logic [cachePkg::INDEX_E-1:0] wIndex,
    input  logic [$clog2(ASSOC)-1:0] wWay,
    input  cachePkg::TagEntry wEntry
);

    localparam int SETS = 1 << cachePkg::INDEX_E;
    localparam int WAY_W = $clog2(ASSOC);

    cachePkg::TagEntry entries [SETS][ASSOC];
    logic [NUM_PORTS-1:0] dupTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < ASSOC; w++) begin
                    entries[s][w] <= '0;
                end
            end
        end else if (we) begin
            entries[wIndex][wWay] <= wEntry;
        end
    end

    // a write to the set being read shows up in the same read
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (re[p]) begin
                for (int w = 0; w < ASSOC; w++) begin
                    if (we && wIndex == rIndex[p] && wWay == WAY_W'(w)) begin
                        rdata[p][w] <= wEntry;
                    end else begin
                        rdata[p][w] <= entries[rIndex[p]][w];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            dupTag[p] = 1'b0;
            for (int a = 0; a < ASSOC; a++) begin
                for (int b = a + 1; b < ASSOC; b++) begin
                    if (rdata[p][a].valid && rdata[p][b].valid
                            && rdata[p][a].tag == rdata[p][b].tag) begin
                        dupTag[p] = 1'b1;
                    end
                end
            end
        end
    end

    // allocation never places one line in two ways of a set
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gUniqueCheck
        assert property (@(posedge clk) disable iff (rst)
            $past(re[p]) && !$past(rst) |-> !dupTag[p])
            else $error("tag read on lane %0d sees a line in two ways", p);
    end

endmodule

// File: design/loadIssue.sv
// rotating request-to-lane assignment, write-port stall, tag and data read addressing
module loadIssue #(
    parameter int NUM_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::LoadReq loadIn [NUM_PORTS],
    input  logic tagWe,
    output logic loadStall [NUM_PORTS],
    output cachePkg::LoadReq laneIn [NUM_PORTS],
    output logic tagRe [NUM_PORTS],
    output logic [cachePkg::INDEX_E-1:0] tagRIndex [NUM_PORTS],
    output logic cacheRe [NUM_PORTS],
    output logic [cachePkg::LINE_E+cachePkg::INDEX_E-3:0] cacheAddr [NUM_PORTS]
);

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int LAST = NUM_PORTS - 1;
    localparam int LINE_E = cachePkg::LINE_E;
    localparam int INDEX_E = cachePkg::INDEX_E;

    logic [PORT_W-1:0] start;
    logic [PORT_W-1:0] src [NUM_PORTS];

    // rotation keeps the blocked lane from always hitting the same input
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= '0;
        end else begin
            start <= start + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            loadStall[i] = 1'b0;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            src[i] = start + PORT_W'(i);
            // last lane gives up its tag port to the miss write
            if (i == LAST && tagWe) begin
                laneIn[i] = '0;
                loadStall[src[i]] = loadIn[src[i]].valid;
            end else begin
                laneIn[i] = loadIn[src[i]];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            tagRe[i] = laneIn[i].valid;
            tagRIndex[i] = laneIn[i].addr[LINE_E +: INDEX_E];
            cacheRe[i] = laneIn[i].valid;
            // word address within one way
            cacheAddr[i] = laneIn[i].addr[LINE_E+INDEX_E-1:2];
        end
    end

endmodule

// File: design/loadLane.sv
// load lane: stage register, tag compare, way select, forward merge and miss classification
module loadLane #(
    parameter int ASSOC = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::LoadReq laneIn,
    input  cachePkg::TagEntry tagRdata [ASSOC],
    input  logic [31:0] cacheRdata [ASSOC],
    input  memcPkg::TransferSlot transfers [memcPkg::NUM_TRANS],
    input  memcPkg::MemcReq memcPending,
    input  logic grant,
    output cachePkg::LaneMiss laneMiss,
    output cachePkg::LoadRes loadOut
);

    localparam int ADDR_W = cachePkg::ADDR_W;
    localparam int LINE_E = cachePkg::LINE_E;
    localparam int TAG_LSB = LINE_E + cachePkg::INDEX_E;

    cachePkg::LoadReq ld;
    logic [cachePkg::LINE_W-1:0] ldLine;
    logic hit;
    logic [31:0] wayData;
    logic [31:0] mergedData;
    logic fullFwd;
    logic inTransfer;
    logic needMiss;

    // held while tag table and data array answer
    always_ff @(posedge clk) begin
        ld <= laneIn;
        if (rst) begin
            ld.valid <= 1'b0;
        end
    end

    assign ldLine = ld.addr[ADDR_W-1:LINE_E];
    assign fullFwd = &ld.fwdMask;

    always_comb begin
        hit = 1'b0;
        wayData = '0;
        for (int w = 0; w < ASSOC; w++) begin
            if (tagRdata[w].valid && tagRdata[w].tag == ld.addr[ADDR_W-1:TAG_LSB]) begin
                hit = 1'b1;
                wayData = cacheRdata[w];
            end
        end
    end

    // store-forwarded bytes win over cache data
    always_comb begin
        mergedData = wayData;
        for (int b = 0; b < 4; b++) begin
            if (ld.fwdMask[b]) begin
                mergedData[8*b +: 8] = ld.fwdData[8*b +: 8];
            end
        end
    end

    // line being fetched by the controller, or by the command not yet taken.
    // tag may already hit here while the data is still missing
    always_comb begin
        inTransfer = memcPending.cmd == memcPkg::REFILL
            && memcPending.readAddr[ADDR_W-1:LINE_E] == ldLine;
        for (int t = 0; t < memcPkg::NUM_TRANS; t++) begin
            if (transfers[t].valid && transfers[t].line == ldLine) begin
                inTransfer = 1'b1;
            end
        end
    end

    // a full forward mask completes regardless of tag state
    assign needMiss = ld.valid && !fullFwd && (inTransfer || !hit);

    always_comb begin
        laneMiss.valid = needMiss;
        laneMiss.fresh = !inTransfer;
        laneMiss.line = ldLine;
    end

    always_comb begin
        loadOut.valid = ld.valid;
        loadOut.tagDst = ld.tagDst;
        loadOut.data = mergedData;
        loadOut.nack = needMiss;
        loadOut.waitRefill = needMiss && (inTransfer || grant);
    end

    // drain only picks lanes that report a fresh miss
    assert property (@(posedge clk) disable iff (rst)
        grant |-> laneMiss.valid && laneMiss.fresh)
        else $error("grant on a lane without a fresh miss");

endmodule

// File: design/missHandler.sv
// miss grant, victim way counter, tag-table write and refill command register
module missHandler #(
    parameter int NUM_PORTS = 2,
    parameter int ASSOC = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::LaneMiss laneMiss [NUM_PORTS],
    input  logic memcStall,
    output logic [NUM_PORTS-1:0] grant,
    output logic tagWe,
    output logic [cachePkg::INDEX_E-1:0] tagWIndex,
    output logic [$clog2(ASSOC)-1:0] tagWWay,
    output cachePkg::TagEntry tagWEntry,
    output memcPkg::MemcReq memcOut
);

    localparam int WAY_W = $clog2(ASSOC);
    localparam int INDEX_E = cachePkg::INDEX_E;
    localparam int CWAY_W = memcPkg::WAY_W;

    memcPkg::MemcCmd cmdQ;
    logic [memcPkg::CLINE_W-1:0] cacheLineQ;
    logic [cachePkg::LINE_W-1:0] lineQ;
    logic [WAY_W-1:0] victim;
    logic canIssue;
    logic granted;
    cachePkg::LaneMiss win;

    // command register free, or its command is taken this cycle
    assign canIssue = cmdQ == memcPkg::NONE || !memcStall;

    // lowest lane with a fresh miss wins
    always_comb begin
        grant = '0;
        granted = 1'b0;
        win = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (!granted && canIssue && laneMiss[i].valid && laneMiss[i].fresh) begin
                grant[i] = 1'b1;
                granted = 1'b1;
                win = laneMiss[i];
            end
        end
    end

    // new entry goes in before the data arrives, lanes see it as in transfer
    assign tagWe = granted;
    assign tagWIndex = win.line[INDEX_E-1:0];
    assign tagWWay = victim;

    always_comb begin
        tagWEntry.valid = 1'b1;
        tagWEntry.tag = win.line[cachePkg::LINE_W-1:INDEX_E];
    end

    // round-robin victim, wraps at ASSOC
    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= '0;
        end else if (granted) begin
            victim <= victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmdQ <= memcPkg::NONE;
        end else if (canIssue) begin
            cmdQ <= granted ? memcPkg::REFILL : memcPkg::NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (granted) begin
            cacheLineQ <= {CWAY_W'(victim), win.line[INDEX_E-1:0]};
            lineQ <= win.line;
        end
    end

    always_comb begin
        memcOut.cmd = cmdQ;
        memcOut.cacheLine = cacheLineQ;
        memcOut.readAddr = {lineQ, {cachePkg::LINE_E{1'b0}}};
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("more than one miss granted in a cycle");

endmodule

// File: design/loadCacheUnit.sv
// top level: load feeder, lane array, miss drain and tag table
module loadCacheUnit #(
    parameter int NUM_PORTS = 2,
    parameter int ASSOC = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::LoadReq loadIn [NUM_PORTS],
    output logic loadStall [NUM_PORTS],
    output logic [cachePkg::LINE_E+cachePkg::INDEX_E-3:0] cacheAddr [NUM_PORTS],
    output logic cacheRe [NUM_PORTS],
    input  logic [31:0] cacheRdata [NUM_PORTS][ASSOC],
    output cachePkg::LoadRes loadOut [NUM_PORTS],
    input  memcPkg::TransferSlot transfers [memcPkg::NUM_TRANS],
    input  logic memcStall,
    output memcPkg::MemcReq memcOut
);

    cachePkg::LoadReq laneIn [NUM_PORTS];
    logic tagRe [NUM_PORTS];
    logic [cachePkg::INDEX_E-1:0] tagRIndex [NUM_PORTS];
    cachePkg::TagEntry tagRdata [NUM_PORTS][ASSOC];
    cachePkg::LaneMiss laneMiss [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant;
    logic tagWe;
    logic [cachePkg::INDEX_E-1:0] tagWIndex;
    logic [$clog2(ASSOC)-1:0] tagWWay;
    cachePkg::TagEntry tagWEntry;

    loadIssue #(.NUM_PORTS(NUM_PORTS)) issue (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .tagWe(tagWe),
        .loadStall(loadStall),
        .laneIn(laneIn),
        .tagRe(tagRe),
        .tagRIndex(tagRIndex),
        .cacheRe(cacheRe),
        .cacheAddr(cacheAddr)
    );

    tagTable #(.NUM_PORTS(NUM_PORTS), .ASSOC(ASSOC)) tags (
        .clk(clk),
        .rst(rst),
        .re(tagRe),
        .rIndex(tagRIndex),
        .rdata(tagRdata),
        .we(tagWe),
        .wIndex(tagWIndex),
        .wWay(tagWWay),
        .wEntry(tagWEntry)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : gLane
        loadLane #(.ASSOC(ASSOC)) lane (
            .clk(clk),
            .rst(rst),
            .laneIn(laneIn[i]),
            .tagRdata(tagRdata[i]),
            .cacheRdata(cacheRdata[i]),
            .transfers(transfers),
            .memcPending(memcOut),
            .grant(grant[i]),
            .laneMiss(laneMiss[i]),
            .loadOut(loadOut[i])
        );
    end

    missHandler #(.NUM_PORTS(NUM_PORTS), .ASSOC(ASSOC)) drain (
        .clk(clk),
        .rst(rst),
        .laneMiss(laneMiss),
        .memcStall(memcStall),
        .grant(grant),
        .tagWe(tagWe),
        .tagWIndex(tagWIndex),
        .tagWWay(tagWWay),
        .tagWEntry(tagWEntry),
        .memcOut(memcOut)
    );

endmodule

// File: tests/tbLoadCacheUnit.sv
// testbench for loadCacheUnit: random loads checked against a tag, victim, transfer and refill model
module tbLoadCacheUnit;

    localparam int NUM_PORTS = 2;
    localparam int ASSOC = 2;
    localparam int NUM_TRANS = memcPkg::NUM_TRANS;
    localparam int SETS = 1 << cachePkg::INDEX_E;
    localparam int LINE_W = cachePkg::LINE_W;
    localparam int TAG_W = cachePkg::TAG_W;
    localparam int CYCLES = 4000;
    localparam int RESULT_TIMEOUT = 3;
    localparam int DRAIN_TIMEOUT = 20;

    logic clk;
    logic rst;
    cachePkg::LoadReq loadIn [NUM_PORTS];
    logic loadStall [NUM_PORTS];
    logic [cachePkg::LINE_E+cachePkg::INDEX_E-3:0] cacheAddr [NUM_PORTS];
    logic cacheRe [NUM_PORTS];
    logic [31:0] cacheRdata [NUM_PORTS][ASSOC];
    cachePkg::LoadRes loadOut [NUM_PORTS];
    memcPkg::TransferSlot transfers [NUM_TRANS];
    logic memcStall;
    memcPkg::MemcReq memcOut;

    integer seed;
    logic [5:0] nextTag;

    // model of tag table, victim counter, command register and transfer slots
    logic mTagValid [SETS][ASSOC];
    logic [TAG_W-1:0] mTag [SETS][ASSOC];
    int mVictim;
    logic mCmdValid;
    logic [LINE_W-1:0] mCmdLine;
    int mCmdWay;
    logic cmdHeld;
    int mStart;
    cachePkg::LoadReq mLane [NUM_PORTS];
    int slotLeft [NUM_TRANS];
    logic [LINE_W-1:0] slotLine [NUM_TRANS];
    int freeIdx;
    logic [5:0] prevAddr [NUM_PORTS];
    logic held [NUM_PORTS];

    // predictions for the current cycle
    logic canIssue;
    int grantLane;
    logic eHit [NUM_PORTS];
    int eHitWay [NUM_PORTS];
    logic eInTr [NUM_PORTS];
    logic eMiss [NUM_PORTS];
    logic eStall [NUM_PORTS];

    // accepted loads still waiting for a result
    int pendTag [$];
    int pendAge [$];
    logic timedOut;

    int testChecks [6];
    int testErrors [6];
    string testName [6];

    loadCacheUnit #(.NUM_PORTS(NUM_PORTS), .ASSOC(ASSOC)) dut (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .loadStall(loadStall),
        .cacheAddr(cacheAddr),
        .cacheRe(cacheRe),
        .cacheRdata(cacheRdata),
        .loadOut(loadOut),
        .transfers(transfers),
        .memcStall(memcStall),
        .memcOut(memcOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cache word as a fixed function of way and word address
    function automatic logic [31:0] wordOf(input int way, input logic [5:0] waddr);
        return {8'(way) ^ 8'ha5, 2'b00, waddr, ~waddr, 2'b11, 8'(waddr * 3 + way)};
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] base, input logic [3:0] mask,
                                               input logic [31:0] fwd);
        logic [31:0] r;
        r = base;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                r[8*b +: 8] = fwd[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic anyHeld();
        logic r;
        r = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            r = r | held[p];
        end
        return r;
    endfunction

    task automatic checkValue(input int test, input logic [63:0] got, input logic [63:0] want,
                              input string what);
        testChecks[test]++;
        if (got !== want) begin
            testErrors[test]++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic newRequest(output cachePkg::LoadReq req);
        logic [1:0] kind;
        req.valid = 1'b1;
        req.tagDst = nextTag;
        nextTag = nextTag + 1'b1;
        // four tags over two sets, so the two ways keep getting replaced
        req.addr = {22'h2c1, 2'($random(seed)), 4'(($random(seed) & 1) * 5),
                    2'($random(seed)), 2'b00};
        kind = 2'($random(seed));
        if (kind == 2'd0) begin
            req.fwdMask = 4'hf;
        end else if (kind == 2'd3) begin
            req.fwdMask = 4'($random(seed));
        end else begin
            req.fwdMask = 4'h0;
        end
        req.fwdData = $random(seed);
    endtask

    task automatic driveInputs(input logic newLoads);
        freeIdx = -1;
        for (int t = 0; t < NUM_TRANS; t++) begin
            transfers[t].valid = slotLeft[t] > 0;
            transfers[t].line = slotLine[t];
            if (slotLeft[t] == 0) begin
                freeIdx = t;
            end
        end
        // controller also stalls while every transfer slot is busy
        memcStall = ($random(seed) % 3 == 0) || (mCmdValid && freeIdx < 0);
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int w = 0; w < ASSOC; w++) begin
                cacheRdata[i][w] = wordOf(w, prevAddr[i]);
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!held[p]) begin
                if (newLoads && ($random(seed) & 3) != 0) begin
                    newRequest(loadIn[p]);
                end else begin
                    loadIn[p] = '0;
                end
            end
        end
    endtask

    task automatic predict();
        cachePkg::LoadReq ld;
        logic [3:0] set;
        logic [LINE_W-1:0] line;
        int last;
        canIssue = !mCmdValid || !memcStall;
        grantLane = -1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            ld = mLane[i];
            line = ld.addr[31:4];
            set = line[3:0];
            eHit[i] = 1'b0;
            eHitWay[i] = 0;
            for (int w = 0; w < ASSOC; w++) begin
                if (mTagValid[set][w] && mTag[set][w] == line[LINE_W-1:4]) begin
                    eHit[i] = 1'b1;
                    eHitWay[i] = w;
                end
            end
            eInTr[i] = mCmdValid && mCmdLine == line;
            for (int t = 0; t < NUM_TRANS; t++) begin
                if (slotLeft[t] > 0 && slotLine[t] == line) begin
                    eInTr[i] = 1'b1;
                end
            end
            eMiss[i] = ld.valid && ld.fwdMask != 4'hf && (eInTr[i] || !eHit[i]);
            if (eMiss[i] && !eInTr[i] && canIssue && grantLane < 0) begin
                grantLane = i;
            end
        end
        // input feeding the last lane is blocked during a tag write
        last = (mStart + NUM_PORTS - 1) % NUM_PORTS;
        for (int p = 0; p < NUM_PORTS; p++) begin
            eStall[p] = p == last && grantLane >= 0 && loadIn[p].valid;
        end
    endtask

    task automatic checkResults();
        cachePkg::LoadReq ld;
        int t;
        int idx;
        int src;
        logic eRe;
        logic [31:0] base;
        for (int i = 0; i < NUM_PORTS; i++) begin
            ld = mLane[i];
            checkValue(5, loadStall[i], eStall[i], $sformatf("loadStall[%0d]", i));
            // data array read follows the request mapped to this lane
            src = (mStart + i) % NUM_PORTS;
            eRe = !(i == NUM_PORTS - 1 && grantLane >= 0) && loadIn[src].valid;
            checkValue(5, cacheRe[i], eRe, $sformatf("cacheRe[%0d]", i));
            if (eRe) begin
                checkValue(5, cacheAddr[i], loadIn[src].addr[7:2],
                           $sformatf("cacheAddr[%0d]", i));
            end
            checkValue(5, loadOut[i].valid, ld.valid, $sformatf("loadOut[%0d] valid", i));
            if (ld.valid) begin
                if (ld.fwdMask == 4'hf) begin
                    t = 2;
                end else if (eInTr[i]) begin
                    t = 3;
                end else if (!eHit[i]) begin
                    t = canIssue ? 0 : 4;
                end else begin
                    t = 1;
                end
                checkValue(t, loadOut[i].tagDst, ld.tagDst, $sformatf("lane %0d tagDst", i));
                checkValue(t, loadOut[i].nack, eMiss[i], $sformatf("lane %0d nack", i));
                checkValue(t, loadOut[i].waitRefill, eMiss[i] && (eInTr[i] || grantLane == i),
                           $sformatf("lane %0d waitRefill", i));
                if (!eMiss[i]) begin
                    base = eHit[i] ? wordOf(eHitWay[i], ld.addr[7:2]) : 32'h0;
                    checkValue(t, loadOut[i].data, mergeBytes(base, ld.fwdMask, ld.fwdData),
                               $sformatf("lane %0d data", i));
                end
            end
            if (loadOut[i].valid === 1'b1) begin
                idx = -1;
                for (int k = 0; k < pendTag.size(); k++) begin
                    if (pendTag[k] == loadOut[i].tagDst) begin
                        idx = k;
                    end
                end
                testChecks[5]++;
                if (idx < 0) begin
                    testErrors[5]++;
                    $display("Mismatch at %0t: result tagDst %0d belongs to no accepted load",
                             $time, loadOut[i].tagDst);
                end else begin
                    pendTag.delete(idx);
                    pendAge.delete(idx);
                end
            end
            prevAddr[i] = cacheAddr[i];
        end
        t = cmdHeld ? 4 : 0;
        checkValue(t, memcOut.cmd, mCmdValid ? memcPkg::REFILL : memcPkg::NONE, "memcOut cmd");
        if (mCmdValid) begin
            checkValue(t, memcOut.cacheLine, {2'(mCmdWay), mCmdLine[3:0]}, "memcOut cacheLine");
            checkValue(t, memcOut.readAddr, {mCmdLine, 4'h0}, "memcOut readAddr");
        end
        for (int k = 0; k < pendAge.size(); k++) begin
            pendAge[k] = pendAge[k] + 1;
            if (pendAge[k] > RESULT_TIMEOUT && !timedOut) begin
                $display("timeout: no result came back for the load with tagDst %0d", pendTag[k]);
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic advanceModel();
        cachePkg::LoadReq ld;
        int src;
        cmdHeld = mCmdValid && !canIssue;
        for (int t = 0; t < NUM_TRANS; t++) begin
            if (slotLeft[t] > 0) begin
                slotLeft[t] = slotLeft[t] - 1;
            end
        end
        // controller takes the command into a free slot for a few cycles
        if (mCmdValid && !memcStall) begin
            slotLeft[freeIdx] = 1 + ($random(seed) & 3);
            slotLine[freeIdx] = mCmdLine;
        end
        if (canIssue) begin
            mCmdValid = grantLane >= 0;
        end
        if (grantLane >= 0) begin
            ld = mLane[grantLane];
            mTagValid[ld.addr[7:4]][mVictim] = 1'b1;
            mTag[ld.addr[7:4]][mVictim] = ld.addr[31:8];
            mCmdLine = ld.addr[31:4];
            mCmdWay = mVictim;
            mVictim = (mVictim + 1) % ASSOC;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            src = (mStart + i) % NUM_PORTS;
            if (i == NUM_PORTS - 1 && grantLane >= 0) begin
                mLane[i] = '0;
            end else begin
                mLane[i] = loadIn[src];
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            held[p] = loadIn[p].valid && eStall[p];
            if (loadIn[p].valid && !eStall[p]) begin
                pendTag.push_back(loadIn[p].tagDst);
                pendAge.push_back(0);
            end
        end
        mStart = (mStart + 1) % NUM_PORTS;
    endtask

    task automatic runCycle(input logic newLoads);
        @(negedge clk);
        driveInputs(newLoads);
        predict();
        // outputs have settled well before the next rising edge
        #10;
        checkResults();
        advanceModel();
    endtask

    initial begin
        int errors;
        int checks;
        int waited;
        seed = 32'ha9ae;
        rst = 1'b1;
        memcStall = 1'b0;
        nextTag = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            loadIn[p] = '0;
            mLane[p] = '0;
            held[p] = 1'b0;
            prevAddr[p] = '0;
            for (int w = 0; w < ASSOC; w++) begin
                cacheRdata[p][w] = '0;
            end
        end
        for (int t = 0; t < NUM_TRANS; t++) begin
            transfers[t] = '0;
            slotLeft[t] = 0;
            slotLine[t] = '0;
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < ASSOC; w++) begin
                mTagValid[s][w] = 1'b0;
                mTag[s][w] = '0;
            end
        end
        mVictim = 0;
        mCmdValid = 1'b0;
        mCmdLine = '0;
        mCmdWay = 0;
        cmdHeld = 1'b0;
        // rotation has already stepped once when the first loads are driven
        mStart = 1;
        timedOut = 1'b0;
        for (int t = 0; t < 6; t++) begin
            testChecks[t] = 0;
            testErrors[t] = 0;
        end
        testName[0] = "fresh miss allocation and refill";
        testName[1] = "hit data with forward merge";
        testName[2] = "full forward mask";
        testName[3] = "line in transfer or pending";
        testName[4] = "refill command stall";
        testName[5] = "port stall and result tracking";

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int cyc = 0; cyc < CYCLES && !timedOut; cyc++) begin
            runCycle(1'b1);
        end
        // let held requests and the last results come through
        waited = 0;
        while (!timedOut && (pendTag.size() != 0 || anyHeld()) && waited < DRAIN_TIMEOUT) begin
            runCycle(1'b0);
            waited++;
        end
        if (!timedOut && (pendTag.size() != 0 || anyHeld())) begin
            $display("timeout: loads still outstanding after %0d drain cycles", DRAIN_TIMEOUT);
            timedOut = 1'b1;
        end

        errors = 0;
        checks = 0;
        for (int t = 0; t < 6; t++) begin
            if (testChecks[t] == 0) begin
                $display("test %0d (%s) never ran a check", t + 1, testName[t]);
                testErrors[t]++;
            end
            $display("test %0d %s: %0d checks, %0d errors", t + 1, testName[t],
                     testChecks[t], testErrors[t]);
            errors += testErrors[t];
            checks += testChecks[t];
        end
        $display("total: %0d checks, %0d errors, timeout %0d", checks, errors, timedOut);
        if (errors == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
design/cachePkg.sv
design/memcPkg.sv
design/tagTable.sv
design/loadIssue.sv
design/loadLane.sv
design/missHandler.sv
design/loadCacheUnit.sv
tests/tbLoadCacheUnit.sv
